// ==== apb_bridge_pkg.sv ====
/*
 * Shared definitions for the AXI4 to APB3 bridge.
 * Holds the bus widths, the FIFO depth, the response, state and opcode
 * enums, and the packed payload structs that travel on every AXI channel
 * and into the APB master. Modules import it inside their bodies and use
 * scoped names in their port lists.
 */
package apb_bridge_pkg;

    // ------------------------------------------------------------------
    // Widths and sizes
    // ------------------------------------------------------------------
    localparam int ADDR_W     = 32;  // AXI and APB address
    localparam int DATA_W     = 32;  // Single word, no strobes
    localparam int ID_W       = 4;   // AXI transaction ID
    localparam int FIFO_DEPTH = 2;   // Entries per channel FIFO

    // ------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------
    // The bridge only ever returns OKAY or SLVERR
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // APB transfer phases
    typedef enum logic [1:0] {
        ST_IDLE   = 2'b00,
        ST_SETUP  = 2'b01,
        ST_ACCESS = 2'b10
    } bridge_state_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } apb_op_e;

    // ------------------------------------------------------------------
    // Channel payloads
    // ------------------------------------------------------------------
    // Shared by AW and AR
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
    } axi_ax_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        axi_resp_e       resp;
    } axi_b_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        axi_resp_e         resp;
    } axi_r_t;

    // One APB transfer as chosen by the control FSM
    typedef struct packed {
        apb_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [ID_W-1:0]   id;
    } apb_cmd_t;

endpackage

// ==== chan_fifo.sv ====
/*
 * Generic in-order channel FIFO, one per AXI channel.
 * The payload type and the depth are parameters. ready_o is high while
 * there is room, valid_o is high while the head holds an item, and a
 * pushed item reaches the head on the following cycle.
 */
`timescale 1ns/1ps

module chan_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 2
) (
    input  logic ACLK,
    input  logic ARESETn,

    input  logic push_i,
    input  T     data_i,
    output logic ready_o,

    output logic valid_o,
    output T     data_o,
    input  logic pop_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign ready_o = (count != CNT_W'(DEPTH));
    assign valid_o = (count != '0);
    assign data_o  = mem[rd_ptr];

    // Storage, written at the tail
    always_ff @(posedge ACLK) begin
        if (push_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    // ------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Idle, or push and pop together
            endcase
        end
    end

    // Overflow and underflow would break the ordering of the channel
    a_no_push_full: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        push_i |-> ready_o
    ) else $error("push into a full channel FIFO");

    a_no_pop_empty: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        pop_i |-> valid_o
    ) else $error("pop from an empty channel FIFO");

endmodule

// ==== bridge_ctrl.sv ====
/*
 * Control FSM of the bridge.
 * In idle it picks the next request from the FIFO heads, reads before
 * writes, and only when the matching response FIFO has room. It then runs
 * one APB setup cycle and an access phase that waits for PREADY. On the
 * PREADY cycle it pushes the response and pops the request entries.
 */
`timescale 1ns/1ps

module bridge_ctrl (
    input  logic                      ACLK,
    input  logic                      ARESETn,

    // Request FIFO heads
    input  logic                      aw_valid_i,
    input  logic                      w_valid_i,
    input  logic                      ar_valid_i,
    input  apb_bridge_pkg::axi_ax_t   aw_head_i,
    input  apb_bridge_pkg::axi_w_t    w_head_i,
    input  apb_bridge_pkg::axi_ax_t   ar_head_i,
    output logic                      aw_pop_o,
    output logic                      w_pop_o,
    output logic                      ar_pop_o,

    // Response FIFO space and pushes
    input  logic                      b_space_i,
    input  logic                      r_space_i,
    output logic                      b_push_o,
    output logic                      r_push_o,

    // APB master control
    output logic                      cmd_load_o,
    output apb_bridge_pkg::apb_cmd_t  cmd_o,
    output logic                      psel_o,
    output logic                      penable_o,
    input  logic                      pready_i
);

    import apb_bridge_pkg::*;

    bridge_state_e state_q;
    bridge_state_e state_d;
    apb_op_e       op_q;          // Direction of the transfer in flight

    logic rd_pick;
    logic wr_pick;
    logic done;

    // ------------------------------------------------------------------
    // Request selection with reads first
    // ------------------------------------------------------------------
    assign rd_pick    = ar_valid_i && r_space_i;
    assign wr_pick    = !rd_pick && aw_valid_i && w_valid_i && b_space_i;
    assign cmd_load_o = (state_q == ST_IDLE) && (rd_pick || wr_pick);

    always_comb begin
        cmd_o.op    = OP_WRITE;
        cmd_o.addr  = aw_head_i.addr;
        cmd_o.wdata = w_head_i.data;
        cmd_o.id    = aw_head_i.id;
        if (rd_pick) begin
            cmd_o.op    = OP_READ;
            cmd_o.addr  = ar_head_i.addr;
            cmd_o.wdata = '0;           // Unused on reads
            cmd_o.id    = ar_head_i.id;
        end
    end

    // ------------------------------------------------------------------
    // APB phase sequencing
    // ------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:   if (cmd_load_o) state_d = ST_SETUP;
            ST_SETUP:  state_d = ST_ACCESS;          // Always one cycle
            ST_ACCESS: if (pready_i) state_d = ST_IDLE;
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= ST_IDLE;
            op_q    <= OP_READ;
        end else begin
            state_q <= state_d;
            if (cmd_load_o) begin
                op_q <= cmd_o.op;
            end
        end
    end

    assign psel_o    = (state_q != ST_IDLE);
    assign penable_o = (state_q == ST_ACCESS);

    // Completion moves the request out and the response in
    assign done     = (state_q == ST_ACCESS) && pready_i;
    assign r_push_o = done && (op_q == OP_READ);
    assign ar_pop_o = done && (op_q == OP_READ);
    assign b_push_o = done && (op_q == OP_WRITE);
    assign aw_pop_o = done && (op_q == OP_WRITE);
    assign w_pop_o  = done && (op_q == OP_WRITE);

    a_penable_needs_psel: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        penable_o |-> psel_o
    ) else $error("PENABLE high without PSEL");

    // Access phase must be preceded by exactly one setup cycle
    a_penable_after_setup: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        $rose(penable_o) |-> $past(psel_o && !penable_o)
    ) else $error("PENABLE rose without a setup cycle");

endmodule

// ==== apb_master.sv ====
/*
 * APB command register and response builder.
 * The command chosen by the control FSM is captured on load and drives
 * PADDR, PWRITE and PWDATA for the whole transfer. The B and R payloads
 * are formed from the stored ID together with PRDATA and PSLVERR, so the
 * response FIFOs can capture them on the PREADY cycle.
 */
`timescale 1ns/1ps

module apb_master (
    input  logic                                ACLK,
    input  logic                                ARESETn,

    input  logic                                cmd_load_i,
    input  apb_bridge_pkg::apb_cmd_t            cmd_i,

    // APB request side
    output logic [apb_bridge_pkg::ADDR_W-1:0]   paddr_o,
    output logic                                pwrite_o,
    output logic [apb_bridge_pkg::DATA_W-1:0]   pwdata_o,

    // APB completion side
    input  logic [apb_bridge_pkg::DATA_W-1:0]   prdata_i,
    input  logic                                pslverr_i,

    // Response payloads towards the B and R FIFOs
    output apb_bridge_pkg::axi_b_t              b_resp_o,
    output apb_bridge_pkg::axi_r_t              r_resp_o
);

    import apb_bridge_pkg::*;

    apb_cmd_t  cmd_q;
    axi_resp_e resp;

    // ------------------------------------------------------------------
    // Command register
    // ------------------------------------------------------------------
    always_ff @(posedge ACLK) begin
        if (cmd_load_i) begin
            cmd_q <= cmd_i;
        end
    end

    assign paddr_o  = cmd_q.addr;
    assign pwrite_o = (cmd_q.op == OP_WRITE);
    assign pwdata_o = cmd_q.wdata;

    // ------------------------------------------------------------------
    // Response builder
    // ------------------------------------------------------------------
    assign resp = pslverr_i ? SLVERR : OKAY;  // EXOKAY and DECERR never used

    always_comb begin
        b_resp_o.id   = cmd_q.id;
        b_resp_o.resp = resp;

        r_resp_o.id   = cmd_q.id;
        r_resp_o.data = prdata_i;
        r_resp_o.resp = resp;
    end

    // A new load never lands within setup and the first access cycle,
    // so PADDR holds from setup into access
    a_addr_stable: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        $past(cmd_load_i, 2) |->
            (!$past(cmd_load_i) && !cmd_load_i && $stable(paddr_o))
    ) else $error("APB address changed during a transfer");

endmodule

// ==== axi2apb_top.sv ====
/*
 * Top level of the AXI4 slave to APB3 master bridge.
 * Places one FIFO on each of the five AXI channels, the control FSM and
 * the APB master, and connects them to the outside ports. Single-beat
 * transfers only, so every read beat leaves with r_last_o set.
 */
`timescale 1ns/1ps

module axi2apb_top (
    input  logic                                ACLK,
    input  logic                                ARESETn,

    // AXI write address
    input  logic                                aw_valid_i,
    input  apb_bridge_pkg::axi_ax_t             aw_i,
    output logic                                aw_ready_o,

    // AXI write data
    input  logic                                w_valid_i,
    input  apb_bridge_pkg::axi_w_t              w_i,
    output logic                                w_ready_o,

    // AXI read address
    input  logic                                ar_valid_i,
    input  apb_bridge_pkg::axi_ax_t             ar_i,
    output logic                                ar_ready_o,

    // AXI write response
    output logic                                b_valid_o,
    output apb_bridge_pkg::axi_b_t              b_o,
    input  logic                                b_ready_i,

    // AXI read data
    output logic                                r_valid_o,
    output apb_bridge_pkg::axi_r_t              r_o,
    output logic                                r_last_o,
    input  logic                                r_ready_i,

    // APB3 master
    output logic                                psel_o,
    output logic                                penable_o,
    output logic                                pwrite_o,
    output logic [apb_bridge_pkg::ADDR_W-1:0]   paddr_o,
    output logic [apb_bridge_pkg::DATA_W-1:0]   pwdata_o,
    input  logic [apb_bridge_pkg::DATA_W-1:0]   prdata_i,
    input  logic                                pready_i,
    input  logic                                pslverr_i
);

    import apb_bridge_pkg::*;

    // FIFO heads towards the control
    logic     aw_head_valid, w_head_valid, ar_head_valid;
    axi_ax_t  aw_head, ar_head;
    axi_w_t   w_head;
    logic     aw_pop, w_pop, ar_pop;

    // Response side
    logic     b_space, r_space;
    logic     b_push, r_push;
    axi_b_t   b_resp;
    axi_r_t   r_resp;

    apb_cmd_t cmd;
    logic     cmd_load;

    assign r_last_o = 1'b1;   // Every read is a single beat

    // ------------------------------------------------------------------
    // Request FIFOs
    // ------------------------------------------------------------------
    chan_fifo #(.T(axi_ax_t), .DEPTH(FIFO_DEPTH)) u_aw_fifo (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .push_i  (aw_valid_i && aw_ready_o),
        .data_i  (aw_i),
        .ready_o (aw_ready_o),
        .valid_o (aw_head_valid),
        .data_o  (aw_head),
        .pop_i   (aw_pop)
    );

    chan_fifo #(.T(axi_w_t), .DEPTH(FIFO_DEPTH)) u_w_fifo (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .push_i  (w_valid_i && w_ready_o),
        .data_i  (w_i),
        .ready_o (w_ready_o),
        .valid_o (w_head_valid),
        .data_o  (w_head),
        .pop_i   (w_pop)
    );

    chan_fifo #(.T(axi_ax_t), .DEPTH(FIFO_DEPTH)) u_ar_fifo (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .push_i  (ar_valid_i && ar_ready_o),
        .data_i  (ar_i),
        .ready_o (ar_ready_o),
        .valid_o (ar_head_valid),
        .data_o  (ar_head),
        .pop_i   (ar_pop)
    );

    // ------------------------------------------------------------------
    // Response FIFOs
    // ------------------------------------------------------------------
    chan_fifo #(.T(axi_b_t), .DEPTH(FIFO_DEPTH)) u_b_fifo (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .push_i  (b_push),
        .data_i  (b_resp),
        .ready_o (b_space),
        .valid_o (b_valid_o),
        .data_o  (b_o),
        .pop_i   (b_valid_o && b_ready_i)
    );

    chan_fifo #(.T(axi_r_t), .DEPTH(FIFO_DEPTH)) u_r_fifo (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .push_i  (r_push),
        .data_i  (r_resp),
        .ready_o (r_space),
        .valid_o (r_valid_o),
        .data_o  (r_o),
        .pop_i   (r_valid_o && r_ready_i)
    );

    // ------------------------------------------------------------------
    // Control and APB datapath
    // ------------------------------------------------------------------
    bridge_ctrl u_ctrl (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .aw_valid_i (aw_head_valid),
        .w_valid_i  (w_head_valid),
        .ar_valid_i (ar_head_valid),
        .aw_head_i  (aw_head),
        .w_head_i   (w_head),
        .ar_head_i  (ar_head),
        .aw_pop_o   (aw_pop),
        .w_pop_o    (w_pop),
        .ar_pop_o   (ar_pop),
        .b_space_i  (b_space),
        .r_space_i  (r_space),
        .b_push_o   (b_push),
        .r_push_o   (r_push),
        .cmd_load_o (cmd_load),
        .cmd_o      (cmd),
        .psel_o     (psel_o),
        .penable_o  (penable_o),
        .pready_i   (pready_i)
    );

    apb_master u_apb (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .cmd_load_i (cmd_load),
        .cmd_i      (cmd),
        .paddr_o    (paddr_o),
        .pwrite_o   (pwrite_o),
        .pwdata_o   (pwdata_o),
        .prdata_i   (prdata_i),
        .pslverr_i  (pslverr_i),
        .b_resp_o   (b_resp),
        .r_resp_o   (r_resp)
    );

endmodule

// ==== tb_clock_gen.sv ====
/*
 * Testbench clock and reset source.
 * Runs ACLK with the given period and holds ARESETn low for the given
 * number of cycles, releasing it on a falling edge.
 */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic ACLK,
    output logic ARESETn
);

    initial begin
        ACLK = 1'b0;
        forever #(PERIOD_NS / 2) ACLK = ~ACLK;
    end

    initial begin
        ARESETn = 1'b0;
        #(RESET_CYCLES * PERIOD_NS) ARESETn = 1'b1;   // Lands on a falling edge
    end

endmodule

// ==== tb_apb_slave.sv ====
/*
 * Testbench APB3 slave with a word memory.
 * Each access gets 0 to 3 random wait states. Addresses with the top bit
 * set answer with PSLVERR and writes there are dropped. The memory starts
 * with a fill pattern derived from each word's byte address.
 */
`timescale 1ns/1ps

module tb_apb_slave #(
    parameter int WORDS = 256
) (
    input  logic        ACLK,
    input  logic        ARESETn,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [31:0] paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o
);

    localparam int IDX_W = $clog2(WORDS);

    logic [31:0]      mem [WORDS];
    logic [1:0]       waits;        // Wait states still to insert
    logic [1:0]       draw;
    logic [IDX_W-1:0] idx;

    assign idx = paddr_i[IDX_W+1:2];

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = 32'h5A5A_0000 ^ (32'(i) << 2);
        end
    end

    // Ends the access in the next cycle
    task complete_access;
        pready_o <= 1'b1;
        if (paddr_i[31]) begin
            pslverr_o <= 1'b1;
            prdata_o  <= '0;
        end else if (pwrite_i) begin
            mem[idx] <= pwdata_i;
        end else begin
            prdata_o <= mem[idx];
        end
    endtask

    always @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            pready_o  <= 1'b0;
            pslverr_o <= 1'b0;
            prdata_o  <= '0;
            waits     <= '0;
        end else begin
            pready_o  <= 1'b0;
            pslverr_o <= 1'b0;
            if (psel_i && !penable_i) begin
                draw = 2'($urandom % 4);     // Setup cycle picks the wait count
                waits <= draw;
                if (draw == 2'd0) complete_access();
            end else if (psel_i && penable_i && !pready_o) begin
                waits <= waits - 2'd1;
                if (waits == 2'd1) complete_access();
            end
        end
    end

endmodule

// ==== tb_axi2apb.sv ====
/*
 * Testbench top for the AXI4 to APB3 bridge.
 * Issues single AXI reads and writes into the DUT, answers the APB side
 * with a memory slave and checks every response against a shadow memory.
 * A monitor watches the APB phases throughout the run.
 */
`timescale 1ns/1ps

module tb_axi2apb;

    import apb_bridge_pkg::*;

    localparam int SEED       = 63676;
    localparam int TIMEOUT    = 200;    // Cycles allowed for any single wait
    localparam int STALL_WAIT = 40;     // Far longer than one APB transfer
    localparam int RANDOM_OPS = 200;

    logic              ACLK;
    logic              ARESETn;
    logic              aw_valid, w_valid, ar_valid;
    logic              aw_ready, w_ready, ar_ready;
    axi_ax_t           aw_req, ar_req;
    axi_w_t            w_req;
    logic              b_valid, b_ready, r_valid, r_ready, r_last;
    axi_b_t            b_rsp;
    axi_r_t            r_rsp;
    logic              psel, penable, pwrite, pready, pslverr;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata, prdata;

    // Reference model and captured responses
    logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
    axi_b_t            exp_b [$];
    axi_r_t            exp_r [$];
    bit                exp_r_data [$];    // Read data is undefined on SLVERR
    axi_b_t            got_b [$];
    axi_r_t            got_r [$];

    int                errors;
    int                checks;
    int                mark;
    int                mon_mark;
    int                apb_fails;
    bit                hung;
    logic              prev_psel, prev_penable, prev_pready;
    logic [ADDR_W-1:0] prev_paddr;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(2)) u_clk (
        .ACLK    (ACLK),
        .ARESETn (ARESETn)
    );

    axi2apb_top DUT (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .aw_valid_i (aw_valid),
        .aw_i       (aw_req),
        .aw_ready_o (aw_ready),
        .w_valid_i  (w_valid),
        .w_i        (w_req),
        .w_ready_o  (w_ready),
        .ar_valid_i (ar_valid),
        .ar_i       (ar_req),
        .ar_ready_o (ar_ready),
        .b_valid_o  (b_valid),
        .b_o        (b_rsp),
        .b_ready_i  (b_ready),
        .r_valid_o  (r_valid),
        .r_o        (r_rsp),
        .r_last_o   (r_last),
        .r_ready_i  (r_ready),
        .psel_o     (psel),
        .penable_o  (penable),
        .pwrite_o   (pwrite),
        .paddr_o    (paddr),
        .pwdata_o   (pwdata),
        .prdata_i   (prdata),
        .pready_i   (pready),
        .pslverr_i  (pslverr)
    );

    tb_apb_slave u_slave (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    // ------------------------------------------------------------------
    // Model, checks and reporting
    // ------------------------------------------------------------------
    function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] key;
        key = addr & 32'h0000_03FC;
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return 32'h5A5A_0000 ^ key;   // Slave fill pattern
    endfunction

    task automatic compare(input string name, input logic [DATA_W-1:0] expected,
                           input logic [DATA_W-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: expected 0x%08h, got 0x%08h at %0t ns",
                     name, expected, actual, $time);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
        errors++;
        hung = 1'b1;
    endtask

    task automatic end_test(input int num, input string name, input bit failed);
        $display("Test %0d %-30s %s", num, name, failed ? "FAILED" : "passed");
        mark = errors;
    endtask

    // ------------------------------------------------------------------
    // AXI stimulus
    // ------------------------------------------------------------------
    task automatic drive_write(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data);
        axi_b_t exp;
        @(posedge ACLK);
        aw_valid    <= 1'b1;
        aw_req.id   <= id;
        aw_req.addr <= addr;
        w_valid     <= 1'b1;
        w_req.data  <= data;
        exp.id   = id;
        exp.resp = addr[ADDR_W-1] ? SLVERR : OKAY;   // Top bit is the error region
        exp_b.push_back(exp);
        if (!addr[ADDR_W-1]) begin
            shadow[addr & 32'h0000_03FC] = data;
        end
    endtask

    task automatic drive_read(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr);
        axi_r_t exp;
        @(posedge ACLK);
        ar_valid    <= 1'b1;
        ar_req.id   <= id;
        ar_req.addr <= addr;
        exp.id   = id;
        exp.resp = addr[ADDR_W-1] ? SLVERR : OKAY;
        exp.data = addr[ADDR_W-1] ? '0 : model_read(addr);
        exp_r.push_back(exp);
        exp_r_data.push_back(!addr[ADDR_W-1]);
    endtask

    // Valid stays high when no handshake comes within the limit
    task automatic await_write(input int limit, output bit accepted);
        int cycles;
        cycles = 0;
        @(negedge ACLK);
        while (!(aw_ready && w_ready) && cycles < limit) begin
            cycles++;
            @(negedge ACLK);
        end
        accepted = aw_ready && w_ready;
        if (accepted) begin
            @(posedge ACLK);
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
        end
    endtask

    task automatic await_read(input int limit, output bit accepted);
        int cycles;
        cycles = 0;
        @(negedge ACLK);
        while (!ar_ready && cycles < limit) begin
            cycles++;
            @(negedge ACLK);
        end
        accepted = ar_ready;
        if (accepted) begin
            @(posedge ACLK);
            ar_valid <= 1'b0;
        end
    endtask

    task automatic do_write(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data);
        bit ok;
        drive_write(id, addr, data);
        await_write(TIMEOUT, ok);
        if (!ok) report_timeout("AW/W handshake");
    endtask

    task automatic do_read(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr);
        bit ok;
        drive_read(id, addr);
        await_read(TIMEOUT, ok);
        if (!ok) report_timeout("AR handshake");
    endtask

    // Takes the next captured responses in order and checks them
    task automatic collect(input bit is_read, input int count);
        int     n;
        int     cycles;
        axi_b_t gb;
        axi_b_t eb;
        axi_r_t gr;
        axi_r_t er;
        for (n = 0; n < count && !hung; n++) begin
            cycles = 0;
            while ((is_read ? got_r.size() : got_b.size()) == 0 && cycles < TIMEOUT) begin
                cycles++;
                @(negedge ACLK);
            end
            if ((is_read ? got_r.size() : got_b.size()) == 0) begin
                report_timeout(is_read ? "R response" : "B response");
            end else if (is_read) begin
                gr = got_r.pop_front();
                er = exp_r.pop_front();
                compare("r_o.id", 32'(er.id), 32'(gr.id));
                compare("r_o.resp", 32'(er.resp), 32'(gr.resp));
                if (exp_r_data.pop_front()) compare("r_o.data", er.data, gr.data);
            end else begin
                gb = got_b.pop_front();
                eb = exp_b.pop_front();
                compare("b_o.id", 32'(eb.id), 32'(gb.id));
                compare("b_o.resp", 32'(eb.resp), 32'(gb.resp));
            end
        end
    endtask

    // ------------------------------------------------------------------
    // APB monitor and response capture, sampled mid-cycle
    // ------------------------------------------------------------------
    always @(negedge ACLK) begin
        if (ARESETn === 1'b1) begin
            mon_mark = errors;
            if (penable && !prev_penable) begin
                compare("psel_o/penable_o setup", 1, 32'(prev_psel && !prev_penable));
            end
            if (prev_psel && !(prev_penable && prev_pready)) begin
                compare("paddr_o", prev_paddr, paddr);   // Same transfer as last cycle
            end
            if (errors != mon_mark) apb_fails++;
            if (b_valid && b_ready) got_b.push_back(b_rsp);
            if (r_valid && r_ready) begin
                got_r.push_back(r_rsp);
                compare("r_last_o", 1, 32'(r_last));
            end
        end
        prev_psel    = psel;
        prev_penable = penable;
        prev_pready  = pready;
        prev_paddr   = paddr;
    end

    initial begin
        wait (hung);
        $display("%0d checks, %0d errors", checks, errors);
        $display("Something failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        int                i;
        int                n_wr;
        int                n_rd;
        int                cycles;
        bit                wr_ok;
        bit                rd_ok;
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;

        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
        ar_valid <= 1'b0;
        aw_req   <= '0;
        w_req    <= '0;
        ar_req   <= '0;
        b_ready  <= 1'b1;
        r_ready  <= 1'b1;
        errors    = 0;
        checks    = 0;
        mark      = 0;
        apb_fails = 0;
        void'($urandom(SEED));

        cycles = 0;
        while (ARESETn !== 1'b1 && cycles < TIMEOUT) begin
            cycles++;
            @(negedge ACLK);
        end
        if (ARESETn !== 1'b1) report_timeout("reset release");
        @(negedge ACLK);

        compare("psel_o", 0, 32'(psel));
        compare("penable_o", 0, 32'(penable));
        compare("b_valid_o", 0, 32'(b_valid));
        compare("r_valid_o", 0, 32'(r_valid));
        compare("aw_ready_o", 1, 32'(aw_ready));
        compare("w_ready_o", 1, 32'(w_ready));
        compare("ar_ready_o", 1, 32'(ar_ready));
        end_test(1, "values after reset", errors != mark);

        do_write(4'h3, 32'h0000_0040, 32'hDEAD_BEEF);
        collect(1'b0, 1);
        do_read(4'h5, 32'h0000_0040);
        collect(1'b1, 1);
        end_test(2, "write then read back", errors != mark);

        for (i = 0; i < RANDOM_OPS; i++) begin
            id   = ID_W'($urandom);
            addr = ADDR_W'(($urandom % 256) << 2);
            if ($urandom % 2 == 0) begin
                do_write(id, addr, DATA_W'($urandom));
                collect(1'b0, 1);
            end else begin
                do_read(id, addr);
                collect(1'b1, 1);
            end
        end
        end_test(3, "random single accesses", errors != mark);

        do_write(4'hA, 32'h8000_0010, 32'hBAD0_BAD0);
        collect(1'b0, 1);
        do_read(4'hB, 32'h8000_0010);
        collect(1'b1, 1);
        do_read(4'hC, 32'h0000_0010);       // Slave word that the error write would alias
        collect(1'b1, 1);
        end_test(4, "error region", errors != mark);

        @(posedge ACLK);
        b_ready <= 1'b0;
        r_ready <= 1'b0;
        n_wr  = 0;
        wr_ok = 1'b1;
        while (wr_ok && n_wr < 8) begin
            drive_write(ID_W'(n_wr + 1), ADDR_W'(32'h320 + 4 * n_wr), DATA_W'($urandom));
            await_write(STALL_WAIT, wr_ok);
            if (wr_ok) n_wr++;
        end
        n_rd  = 0;
        rd_ok = 1'b1;
        while (rd_ok && n_rd < 8) begin
            drive_read(ID_W'(n_rd + 8), ADDR_W'(32'h190 + 4 * n_rd));
            await_read(STALL_WAIT, rd_ok);
            if (rd_ok) n_rd++;
        end
        // Response FIFO plus request FIFO fill up before ready drops
        compare("writes accepted before stall", 32'(2 * FIFO_DEPTH), 32'(n_wr));
        compare("reads accepted before stall", 32'(2 * FIFO_DEPTH), 32'(n_rd));
        @(posedge ACLK);
        b_ready <= 1'b1;
        r_ready <= 1'b1;
        fork
            begin
                if (!wr_ok) await_write(TIMEOUT, wr_ok);
            end
            begin
                if (!rd_ok) await_read(TIMEOUT, rd_ok);
            end
        join
        if (!wr_ok || !rd_ok) report_timeout("request handshake after release");
        collect(1'b0, exp_b.size());
        collect(1'b1, exp_r.size());
        compare("unclaimed responses", 0, 32'(got_b.size() + got_r.size()));
        end_test(5, "back-pressure and ordering", errors != mark);

        end_test(6, "APB protocol monitor", apb_fails != 0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
apb_bridge_pkg.sv
chan_fifo.sv
bridge_ctrl.sv
apb_master.sv
axi2apb_top.sv
tb_clock_gen.sv
tb_apb_slave.sv
tb_axi2apb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the bridge testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_axi2apb -f project.f \
    || { echo "Build failed"; exit 1; }

out=$(./obj_dir/Vtb_axi2apb)
echo "$out"

echo "$out" | grep -q "Everything OK" && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }
